//--- logic/isa_pkg.sv
// ======================================================================
// integer ISA definitions
// word size and register file geometry
// ======================================================================
`default_nettype none

package isa_pkg;

    localparam int XLEN     = 32;
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 32;

    typedef logic [REG_AW-1:0] reg_addr_t;
    typedef logic [XLEN-1:0]   word_t;

    localparam reg_addr_t REG_ZERO = '0;

endpackage

`default_nettype wire

//--- logic/hazard_pkg.sv
// ======================================================================
// hazard control definitions
// forwarding source encoding and pipeline stage descriptor
// ======================================================================
`default_nettype none

package hazard_pkg;

    typedef enum logic [1:0] {
        FWD_RF = 2'd0,
        FWD_EX = 2'd1,
        FWD_LS = 2'd2
    } fwd_sel_t;

    typedef struct packed {
        logic               valid;
        isa_pkg::reg_addr_t rd;
        logic               rd_wen;
        logic               mem_read;
        // source fields only live in ID/EX
        isa_pkg::reg_addr_t rs1;
        isa_pkg::reg_addr_t rs2;
        logic               rs1_en;
        logic               rs2_en;
        isa_pkg::word_t     result;
    } stage_desc_t;

endpackage

`default_nettype wire

//--- logic/hdu.sv
// ======================================================================
// hazard detection unit
// forwarding selects for execute and branch operands, load-use stall
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

module hdu (
    input  hazard_pkg::stage_desc_t i_id_ex,
    input  hazard_pkg::stage_desc_t i_ex_ls,
    input  hazard_pkg::stage_desc_t i_ls_wb,
    input  logic                    i_valid,
    input  isa_pkg::reg_addr_t      i_rs1,
    input  isa_pkg::reg_addr_t      i_rs2,
    input  logic                    i_rs1_en,
    input  logic                    i_rs2_en,
    input  logic                    i_is_branch,
    output hazard_pkg::fwd_sel_t    o_ex_sel1,
    output hazard_pkg::fwd_sel_t    o_ex_sel2,
    output hazard_pkg::fwd_sel_t    o_br_sel1,
    output hazard_pkg::fwd_sel_t    o_br_sel2,
    output logic                    o_stall
);

    // stage holds a live write to a non-zero register matching src
    function automatic logic writes_src(hazard_pkg::stage_desc_t s, isa_pkg::reg_addr_t src);
        return s.valid & s.rd_wen & (s.rd != isa_pkg::REG_ZERO) & (s.rd == src);
    endfunction

    // nearer stage wins so the newest value is used
    function automatic hazard_pkg::fwd_sel_t encode_sel(logic near_hit, logic far_hit);
        if (near_hit) begin
            return hazard_pkg::FWD_EX;
        end else if (far_hit) begin
            return hazard_pkg::FWD_LS;
        end
        return hazard_pkg::FWD_RF;
    endfunction

    logic id_ex_hit1;
    logic id_ex_hit2;
    logic br_near1;
    logic br_near2;
    logic br_far1;
    logic br_far2;
    logic load_use;
    logic ctrl_load_use;

    // data hazards seen by the instruction in ID/EX
    assign o_ex_sel1 = encode_sel(writes_src(i_ex_ls, i_id_ex.rs1),
                                  writes_src(i_ls_wb, i_id_ex.rs1));
    assign o_ex_sel2 = encode_sel(writes_src(i_ex_ls, i_id_ex.rs2),
                                  writes_src(i_ls_wb, i_id_ex.rs2));

    // control hazards, branch compare happens in decode
    assign id_ex_hit1 = writes_src(i_id_ex, i_rs1);
    assign id_ex_hit2 = writes_src(i_id_ex, i_rs2);

    // a load in ID/EX has no result yet
    assign br_near1 = i_is_branch & id_ex_hit1 & ~i_id_ex.mem_read;
    assign br_near2 = i_is_branch & id_ex_hit2 & ~i_id_ex.mem_read;
    assign br_far1  = i_is_branch & ~id_ex_hit1 & writes_src(i_ex_ls, i_rs1);
    assign br_far2  = i_is_branch & ~id_ex_hit2 & writes_src(i_ex_ls, i_rs2);

    assign o_br_sel1 = encode_sel(br_near1, br_far1);
    assign o_br_sel2 = encode_sel(br_near2, br_far2);

    // no zero-register test on either stall
    assign load_use = i_id_ex.valid & i_id_ex.mem_read & i_valid
                    & ((i_rs1_en & (i_rs1 == i_id_ex.rd))
                     | (i_rs2_en & (i_rs2 == i_id_ex.rd)));

    assign ctrl_load_use = i_is_branch & i_id_ex.valid & i_id_ex.mem_read
                         & ((i_rs1 == i_id_ex.rd) | (i_rs2 == i_id_ex.rd));

    assign o_stall = load_use | ctrl_load_use;

endmodule

`default_nettype wire

//--- logic/stage_track.sv
// ======================================================================
// pipeline stage tracker
// ID/EX, EX/LS and LS/WB descriptors with bubble insertion
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

module stage_track (
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  logic                    i_valid,
    input  logic                    i_stall,
    input  isa_pkg::reg_addr_t      i_rs1,
    input  isa_pkg::reg_addr_t      i_rs2,
    input  logic                    i_rs1_en,
    input  logic                    i_rs2_en,
    input  isa_pkg::reg_addr_t      i_rd,
    input  logic                    i_rd_wen,
    input  logic                    i_mem_read,
    input  isa_pkg::word_t          i_result,
    input  isa_pkg::word_t          i_op1,
    input  isa_pkg::word_t          i_op2,
    output hazard_pkg::stage_desc_t o_id_ex,
    output hazard_pkg::stage_desc_t o_ex_ls,
    output hazard_pkg::stage_desc_t o_ls_wb,
    output isa_pkg::word_t          o_id_ex_op1,
    output isa_pkg::word_t          o_id_ex_op2
);

    hazard_pkg::stage_desc_t id_ex_d;
    hazard_pkg::stage_desc_t ex_ls_d;

    // IF/ID descriptor, bubble unless it issues
    always_comb begin
        id_ex_d          = '0;
        id_ex_d.valid    = i_valid & ~i_stall;
        id_ex_d.rd       = i_rd;
        id_ex_d.rd_wen   = i_rd_wen;
        id_ex_d.mem_read = i_mem_read;
        id_ex_d.rs1      = i_rs1;
        id_ex_d.rs2      = i_rs2;
        id_ex_d.rs1_en   = i_rs1_en;
        id_ex_d.rs2_en   = i_rs2_en;
        id_ex_d.result   = i_result;
    end

    // sources are done with once execute has its operands
    always_comb begin
        ex_ls_d        = o_id_ex;
        ex_ls_d.rs1    = '0;
        ex_ls_d.rs2    = '0;
        ex_ls_d.rs1_en = 1'b0;
        ex_ls_d.rs2_en = 1'b0;
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_id_ex     <= '0;
            o_ex_ls     <= '0;
            o_ls_wb     <= '0;
            o_id_ex_op1 <= '0;
            o_id_ex_op2 <= '0;
        end else begin
            o_id_ex     <= id_ex_d;
            o_ex_ls     <= ex_ls_d;
            o_ls_wb     <= o_ex_ls;
            o_id_ex_op1 <= i_op1;
            o_id_ex_op2 <= i_op2;
        end
    end

endmodule

`default_nettype wire

//--- logic/operand_fwd.sv
// ======================================================================
// operand forwarding muxes
// execute operands and decode-stage branch operands
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

module operand_fwd (
    input  hazard_pkg::fwd_sel_t i_ex_sel1,
    input  hazard_pkg::fwd_sel_t i_ex_sel2,
    input  hazard_pkg::fwd_sel_t i_br_sel1,
    input  hazard_pkg::fwd_sel_t i_br_sel2,
    input  isa_pkg::word_t       i_id_ex_op1,
    input  isa_pkg::word_t       i_id_ex_op2,
    input  isa_pkg::word_t       i_rf_op1,
    input  isa_pkg::word_t       i_rf_op2,
    input  isa_pkg::word_t       i_id_ex_res,
    input  isa_pkg::word_t       i_ex_ls_res,
    input  isa_pkg::word_t       i_ls_wb_res,
    output isa_pkg::word_t       o_ex_op1,
    output isa_pkg::word_t       o_ex_op2,
    output isa_pkg::word_t       o_br_op1,
    output isa_pkg::word_t       o_br_op2
);

    function automatic isa_pkg::word_t pick(hazard_pkg::fwd_sel_t sel, isa_pkg::word_t base,
                                            isa_pkg::word_t near, isa_pkg::word_t far);
        case (sel)
            hazard_pkg::FWD_EX: return near;
            hazard_pkg::FWD_LS: return far;
            default:            return base;
        endcase
    endfunction

    // execute reads one and two stages ahead of ID/EX
    assign o_ex_op1 = pick(i_ex_sel1, i_id_ex_op1, i_ex_ls_res, i_ls_wb_res);
    assign o_ex_op2 = pick(i_ex_sel2, i_id_ex_op2, i_ex_ls_res, i_ls_wb_res);

    // branch compare sits in decode, so one stage earlier
    assign o_br_op1 = pick(i_br_sel1, i_rf_op1, i_id_ex_res, i_ex_ls_res);
    assign o_br_op2 = pick(i_br_sel2, i_rf_op2, i_id_ex_res, i_ex_ls_res);

endmodule

`default_nettype wire

//--- logic/reg_file.sv
// ======================================================================
// integer register file, 32 x 32
// x0 reads zero, same-cycle write passes through to the reads
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  logic               i_clk,
    input  logic               i_arst_n,
    input  logic               i_wen,
    input  isa_pkg::reg_addr_t i_waddr,
    input  isa_pkg::word_t     i_wdata,
    input  isa_pkg::reg_addr_t i_raddr1,
    input  isa_pkg::reg_addr_t i_raddr2,
    output isa_pkg::word_t     o_rdata1,
    output isa_pkg::word_t     o_rdata2
);

    isa_pkg::word_t regs [isa_pkg::NUM_REGS];
    logic           wr_live;

    function automatic isa_pkg::word_t read_port(isa_pkg::reg_addr_t addr, logic wr,
                                                 isa_pkg::reg_addr_t waddr,
                                                 isa_pkg::word_t wdata,
                                                 isa_pkg::word_t stored);
        if (addr == isa_pkg::REG_ZERO) begin
            return '0;
        end else if (wr && (waddr == addr)) begin
            return wdata;
        end
        return stored;
    endfunction

    assign wr_live = i_wen & (i_waddr != isa_pkg::REG_ZERO);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    assign o_rdata1 = read_port(i_raddr1, wr_live, i_waddr, i_wdata, regs[i_raddr1]);
    assign o_rdata2 = read_port(i_raddr2, wr_live, i_waddr, i_wdata, regs[i_raddr2]);

endmodule

`default_nettype wire

//--- logic/hazard_top.sv
// ======================================================================
// pipeline hazard core
// stage tracking, register file, hazard detection and forwarding
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

module hazard_top (
    input  logic               i_clk,
    input  logic               i_arst_n,
    input  logic               i_valid,
    input  isa_pkg::reg_addr_t i_rs1,
    input  isa_pkg::reg_addr_t i_rs2,
    input  logic               i_rs1_en,
    input  logic               i_rs2_en,
    input  isa_pkg::reg_addr_t i_rd,
    input  logic               i_rd_wen,
    input  logic               i_mem_read,
    input  logic               i_is_branch,
    input  isa_pkg::word_t     i_result,
    output logic               o_stall,
    output logic               o_ex_valid,
    output isa_pkg::word_t     o_ex_op1,
    output isa_pkg::word_t     o_ex_op2,
    output isa_pkg::word_t     o_br_op1,
    output isa_pkg::word_t     o_br_op2
);

    hazard_pkg::stage_desc_t id_ex;
    hazard_pkg::stage_desc_t ex_ls;
    hazard_pkg::stage_desc_t ls_wb;
    hazard_pkg::fwd_sel_t    ex_sel1;
    hazard_pkg::fwd_sel_t    ex_sel2;
    hazard_pkg::fwd_sel_t    br_sel1;
    hazard_pkg::fwd_sel_t    br_sel2;
    isa_pkg::word_t          rf_op1;
    isa_pkg::word_t          rf_op2;
    isa_pkg::word_t          id_ex_op1;
    isa_pkg::word_t          id_ex_op2;

    assign o_ex_valid = id_ex.valid;

    hdu hdu_inst (
        .i_id_ex     (id_ex),
        .i_ex_ls     (ex_ls),
        .i_ls_wb     (ls_wb),
        .i_valid     (i_valid),
        .i_rs1       (i_rs1),
        .i_rs2       (i_rs2),
        .i_rs1_en    (i_rs1_en),
        .i_rs2_en    (i_rs2_en),
        .i_is_branch (i_is_branch),
        .o_ex_sel1   (ex_sel1),
        .o_ex_sel2   (ex_sel2),
        .o_br_sel1   (br_sel1),
        .o_br_sel2   (br_sel2),
        .o_stall     (o_stall)
    );

    stage_track stage_track_inst (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_valid     (i_valid),
        .i_stall     (o_stall),
        .i_rs1       (i_rs1),
        .i_rs2       (i_rs2),
        .i_rs1_en    (i_rs1_en),
        .i_rs2_en    (i_rs2_en),
        .i_rd        (i_rd),
        .i_rd_wen    (i_rd_wen),
        .i_mem_read  (i_mem_read),
        .i_result    (i_result),
        .i_op1       (rf_op1),
        .i_op2       (rf_op2),
        .o_id_ex     (id_ex),
        .o_ex_ls     (ex_ls),
        .o_ls_wb     (ls_wb),
        .o_id_ex_op1 (id_ex_op1),
        .o_id_ex_op2 (id_ex_op2)
    );

    operand_fwd operand_fwd_inst (
        .i_ex_sel1   (ex_sel1),
        .i_ex_sel2   (ex_sel2),
        .i_br_sel1   (br_sel1),
        .i_br_sel2   (br_sel2),
        .i_id_ex_op1 (id_ex_op1),
        .i_id_ex_op2 (id_ex_op2),
        .i_rf_op1    (rf_op1),
        .i_rf_op2    (rf_op2),
        .i_id_ex_res (id_ex.result),
        .i_ex_ls_res (ex_ls.result),
        .i_ls_wb_res (ls_wb.result),
        .o_ex_op1    (o_ex_op1),
        .o_ex_op2    (o_ex_op2),
        .o_br_op1    (o_br_op1),
        .o_br_op2    (o_br_op2)
    );

    // writeback from LS/WB, x0 filtered inside
    reg_file reg_file_inst (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_wen    (ls_wb.valid & ls_wb.rd_wen),
        .i_waddr  (ls_wb.rd),
        .i_wdata  (ls_wb.result),
        .i_raddr1 (i_rs1),
        .i_raddr2 (i_rs2),
        .o_rdata1 (rf_op1),
        .o_rdata2 (rf_op2)
    );

endmodule

`default_nettype wire

//--- tb/hazard_tb.sv
// ======================================================================
// hazard core testbench
// random instruction stream checked against a shadow register model
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

module hazard_tb;

    localparam int NUM_INSTR   = 2000;
    localparam int CYCLE_LIMIT = 3 * NUM_INSTR + 100;

    logic               i_clk;
    logic               i_arst_n;
    logic               i_valid;
    isa_pkg::reg_addr_t i_rs1;
    isa_pkg::reg_addr_t i_rs2;
    logic               i_rs1_en;
    logic               i_rs2_en;
    isa_pkg::reg_addr_t i_rd;
    logic               i_rd_wen;
    logic               i_mem_read;
    logic               i_is_branch;
    isa_pkg::word_t     i_result;
    logic               o_stall;
    logic               o_ex_valid;
    isa_pkg::word_t     o_ex_op1;
    isa_pkg::word_t     o_ex_op2;
    isa_pkg::word_t     o_br_op1;
    isa_pkg::word_t     o_br_op2;

    // reference model state in program order
    isa_pkg::word_t     shadow [isa_pkg::NUM_REGS];
    logic               idex_valid;
    logic               idex_load;
    isa_pkg::reg_addr_t idex_rd;
    logic               ex_pending;
    isa_pkg::word_t     exp_op1;
    isa_pkg::word_t     exp_op2;
    logic               holding;

    int          pass_count = 0;
    int          fail_count = 0;
    int          issued     = 0;
    int          stalls     = 0;
    int          branches   = 0;
    int          cycles     = 0;

    hazard_top hazard_top_inst (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_valid     (i_valid),
        .i_rs1       (i_rs1),
        .i_rs2       (i_rs2),
        .i_rs1_en    (i_rs1_en),
        .i_rs2_en    (i_rs2_en),
        .i_rd        (i_rd),
        .i_rd_wen    (i_rd_wen),
        .i_mem_read  (i_mem_read),
        .i_is_branch (i_is_branch),
        .i_result    (i_result),
        .o_stall     (o_stall),
        .o_ex_valid  (o_ex_valid),
        .o_ex_op1    (o_ex_op1),
        .o_ex_op2    (o_ex_op2),
        .o_br_op1    (o_br_op1),
        .o_br_op2    (o_br_op2)
    );

    always #5 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: no end of run after %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    task automatic check_word(input string name, input isa_pkg::word_t exp,
                              input isa_pkg::word_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic drive_idle();
        i_valid     = 1'b0;
        i_rs1       = '0;
        i_rs2       = '0;
        i_rs1_en    = 1'b0;
        i_rs2_en    = 1'b0;
        i_rd        = '0;
        i_rd_wen    = 1'b0;
        i_mem_read  = 1'b0;
        i_is_branch = 1'b0;
        i_result    = '0;
    endtask

    // small register range so hazards come up often
    task automatic drive_random_instr();
        i_valid     = 1'b1;
        i_rs1       = isa_pkg::reg_addr_t'($urandom_range(7, 0));
        i_rs2       = isa_pkg::reg_addr_t'($urandom_range(7, 0));
        i_rs1_en    = ($urandom_range(3, 0) != 0);
        i_rs2_en    = ($urandom_range(3, 0) != 0);
        i_rd        = isa_pkg::reg_addr_t'($urandom_range(7, 0));
        i_is_branch = ($urandom_range(4, 0) == 0);
        i_mem_read  = ~i_is_branch & ($urandom_range(3, 0) == 0);
        i_rd_wen    = ~i_is_branch & ($urandom_range(7, 0) != 0);
        i_result    = $urandom;
    endtask

    function automatic isa_pkg::word_t shadow_val(input isa_pkg::reg_addr_t r);
        return (r == isa_pkg::REG_ZERO) ? '0 : shadow[r];
    endfunction

    // data and control load-use against the last issued instruction
    function automatic logic predict_stall();
        logic data_hit;
        logic ctrl_hit;
        data_hit = idex_valid & idex_load & i_valid
                 & ((i_rs1_en & (i_rs1 == idex_rd)) | (i_rs2_en & (i_rs2 == idex_rd)));
        ctrl_hit = i_is_branch & idex_valid & idex_load
                 & ((i_rs1 == idex_rd) | (i_rs2 == idex_rd));
        return data_hit | ctrl_hit;
    endfunction

    task automatic step_cycle(input bit allow_new);
        logic pred_stall;
        logic issue;
        @(posedge i_clk);
        #1;
        if (!holding) begin
            if (allow_new && ($urandom_range(7, 0) != 0)) begin
                drive_random_instr();
            end else begin
                drive_idle();
            end
        end
        #3;
        check_flag("o_ex_valid", ex_pending, o_ex_valid);
        if (ex_pending) begin
            check_word("o_ex_op1", exp_op1, o_ex_op1);
            check_word("o_ex_op2", exp_op2, o_ex_op2);
        end
        pred_stall = predict_stall();
        check_flag("o_stall", pred_stall, o_stall);
        issue = i_valid & ~pred_stall;
        if (issue && i_is_branch) begin
            check_word("o_br_op1", shadow_val(i_rs1), o_br_op1);
            check_word("o_br_op2", shadow_val(i_rs2), o_br_op2);
            branches++;
        end
        if (pred_stall) begin
            stalls++;
        end
        holding    = i_valid & pred_stall;
        ex_pending = issue;
        idex_valid = issue;
        if (issue) begin
            exp_op1   = shadow_val(i_rs1);
            exp_op2   = shadow_val(i_rs2);
            idex_load = i_mem_read;
            idex_rd   = i_rd;
            if (i_rd_wen && (i_rd != isa_pkg::REG_ZERO)) begin
                shadow[i_rd] = i_result;
            end
            issued++;
        end
    endtask

    task automatic check_idle_outputs();
        check_flag("o_stall", 1'b0, o_stall);
        check_flag("o_ex_valid", 1'b0, o_ex_valid);
        check_word("o_ex_op1", '0, o_ex_op1);
        check_word("o_ex_op2", '0, o_ex_op2);
    endtask

    task automatic reset_test();
        int errs_before;
        errs_before = fail_count;
        repeat (15) @(posedge i_clk);
        #4;
        check_idle_outputs();
        @(posedge i_clk);
        #1;
        i_arst_n = 1'b1;
        #3;
        check_idle_outputs();
        $display("test reset: %0d errors", fail_count - errs_before);
    endtask

    task automatic stream_test();
        int errs_before;
        errs_before = fail_count;
        while (issued < NUM_INSTR) begin
            step_cycle(1'b1);
        end
        // last issue still owes its execute operands
        step_cycle(1'b0);
        $display("test stream: %0d instructions, %0d stalls, %0d branches, %0d errors",
                 issued, stalls, branches, fail_count - errs_before);
    endtask

    initial begin
        void'($urandom(32'hf917));
        i_clk      = 1'b0;
        i_arst_n   = 1'b0;
        drive_idle();
        for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        idex_valid = 1'b0;
        idex_load  = 1'b0;
        idex_rd    = '0;
        ex_pending = 1'b0;
        exp_op1    = '0;
        exp_op2    = '0;
        holding    = 1'b0;
        reset_test();
        stream_test();
        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
logic/isa_pkg.sv
logic/hazard_pkg.sv
logic/hdu.sv
logic/stage_track.sv
logic/operand_fwd.sv
logic/reg_file.sv
logic/hazard_top.sv
tb/hazard_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module hazard_tb -f build.f -o hazard_sim

./obj_dir/hazard_sim > sim.log
cat sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation passed"
